/* list.f */
rtl/axil_bridge_pkg.sv
rtl/mem_fwd_decoder.sv
rtl/bridge_queue.sv
rtl/axil_master_engine.sv
rtl/mem_rev_packer.sv
rtl/axil_bridge_top.sv
tests/axil_mem_model.sv
tests/tb_axil_bridge.sv

/* rtl/axil_bridge_pkg.sv */
`default_nettype none

package axil_bridge_pkg;

  // Default bus widths, the top level passes them down as module parameters
  localparam int addr_width_gp = 32;
  localparam int data_width_gp = 32;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_msg_type_e;

  // Log2 of the byte count, code 3 is illegal
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } mem_msg_size_e;

  // Forward and reverse header
  typedef struct packed
  {
    mem_msg_type_e              msg_type;
    mem_msg_size_e              size;
    logic [addr_width_gp-1:0]   addr;
  } mem_header_s;

  // Decoded request, one AXI-Lite access
  typedef struct packed
  {
    logic                       write;
    logic [addr_width_gp-1:0]   addr;
    logic [data_width_gp-1:0]   data;
    logic [data_width_gp/8-1:0] strb;
  } axil_req_s;

endpackage

`default_nettype wire

/* rtl/axil_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_bridge_top
#(
  parameter int addr_width_p = axil_bridge_pkg::addr_width_gp,
  parameter int data_width_p = axil_bridge_pkg::data_width_gp
)
(
  input  wire                                clk_i,
  input  wire                                arst_n_i,
  input  wire axil_bridge_pkg::mem_header_s  fwd_header_i,
  input  wire [data_width_p-1:0]             fwd_data_i,
  input  wire                                fwd_v_i,
  output logic                               fwd_ready_and_o,
  output axil_bridge_pkg::mem_header_s       rev_header_o,
  output logic [data_width_p-1:0]            rev_data_o,
  output logic                               rev_v_o,
  input  wire                                rev_ready_and_i,
  output logic [addr_width_p-1:0]            m_axil_awaddr_o,
  output logic                               m_axil_awvalid_o,
  input  wire                                m_axil_awready_i,
  output logic [data_width_p-1:0]            m_axil_wdata_o,
  output logic [data_width_p/8-1:0]          m_axil_wstrb_o,
  output logic                               m_axil_wvalid_o,
  input  wire                                m_axil_wready_i,
  input  wire [1:0]                          m_axil_bresp_i,
  input  wire                                m_axil_bvalid_i,
  output logic                               m_axil_bready_o,
  output logic [addr_width_p-1:0]            m_axil_araddr_o,
  output logic                               m_axil_arvalid_o,
  input  wire                                m_axil_arready_i,
  input  wire [data_width_p-1:0]             m_axil_rdata_i,
  input  wire [1:0]                          m_axil_rresp_i,
  input  wire                                m_axil_rvalid_i,
  output logic                               m_axil_rready_o
);

  axil_bridge_pkg::axil_req_s   req_in;
  axil_bridge_pkg::axil_req_s   req_head;
  axil_bridge_pkg::mem_header_s hdr_in;
  axil_bridge_pkg::mem_header_s hdr_head;
  logic                         req_push;
  logic                         req_pop;
  logic                         req_valid;
  logic                         req_full;
  logic                         hdr_push;
  logic                         hdr_pop;
  logic                         hdr_valid;
  logic                         hdr_full;
  logic                         done;
  logic                         resp_full;
  logic [data_width_p-1:0]      rdata;

  mem_fwd_decoder #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p)
  ) decoder (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .fwd_header_i(fwd_header_i),
    .fwd_data_i(fwd_data_i),
    .fwd_v_i(fwd_v_i),
    .fwd_ready_and_o(fwd_ready_and_o),
    .req_full_i(req_full),
    .hdr_full_i(hdr_full),
    .req_push_o(req_push),
    .req_o(req_in),
    .hdr_push_o(hdr_push),
    .hdr_o(hdr_in)
  );

  bridge_queue #(
    .payload_t(axil_bridge_pkg::axil_req_s),
    .depth_p(2)
  ) req_queue (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .push_i(req_push),
    .data_i(req_in),
    .pop_i(req_pop),
    .data_o(req_head),
    .valid_o(req_valid),
    .full_o(req_full)
  );

  // Headers wait here until the matching reverse beat is accepted
  bridge_queue #(
    .payload_t(axil_bridge_pkg::mem_header_s),
    .depth_p(2)
  ) hdr_queue (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .push_i(hdr_push),
    .data_i(hdr_in),
    .pop_i(hdr_pop),
    .data_o(hdr_head),
    .valid_o(hdr_valid),
    .full_o(hdr_full)
  );

  axil_master_engine #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p)
  ) engine (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .req_i(req_head),
    .req_valid_i(req_valid),
    .resp_full_i(resp_full),
    .req_pop_o(req_pop),
    .done_o(done),
    .rdata_o(rdata),
    .m_axil_awaddr_o(m_axil_awaddr_o),
    .m_axil_awvalid_o(m_axil_awvalid_o),
    .m_axil_awready_i(m_axil_awready_i),
    .m_axil_wdata_o(m_axil_wdata_o),
    .m_axil_wstrb_o(m_axil_wstrb_o),
    .m_axil_wvalid_o(m_axil_wvalid_o),
    .m_axil_wready_i(m_axil_wready_i),
    .m_axil_bresp_i(m_axil_bresp_i),
    .m_axil_bvalid_i(m_axil_bvalid_i),
    .m_axil_bready_o(m_axil_bready_o),
    .m_axil_araddr_o(m_axil_araddr_o),
    .m_axil_arvalid_o(m_axil_arvalid_o),
    .m_axil_arready_i(m_axil_arready_i),
    .m_axil_rdata_i(m_axil_rdata_i),
    .m_axil_rresp_i(m_axil_rresp_i),
    .m_axil_rvalid_i(m_axil_rvalid_i),
    .m_axil_rready_o(m_axil_rready_o)
  );

  mem_rev_packer #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p)
  ) packer (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .done_i(done),
    .rdata_i(rdata),
    .hdr_i(hdr_head),
    .hdr_valid_i(hdr_valid),
    .rev_ready_and_i(rev_ready_and_i),
    .hdr_pop_o(hdr_pop),
    .full_o(resp_full),
    .rev_header_o(rev_header_o),
    .rev_data_o(rev_data_o),
    .rev_v_o(rev_v_o)
  );

endmodule

`default_nettype wire

/* rtl/axil_master_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_master_engine
#(
  parameter int addr_width_p = axil_bridge_pkg::addr_width_gp,
  parameter int data_width_p = axil_bridge_pkg::data_width_gp
)
(
  input  wire                              clk_i,
  input  wire                              arst_n_i,
  input  wire axil_bridge_pkg::axil_req_s  req_i,
  input  wire                              req_valid_i,
  input  wire                              resp_full_i,
  output logic                             req_pop_o,
  output logic                             done_o,
  output logic [data_width_p-1:0]          rdata_o,
  output logic [addr_width_p-1:0]          m_axil_awaddr_o,
  output logic                             m_axil_awvalid_o,
  input  wire                              m_axil_awready_i,
  output logic [data_width_p-1:0]          m_axil_wdata_o,
  output logic [data_width_p/8-1:0]        m_axil_wstrb_o,
  output logic                             m_axil_wvalid_o,
  input  wire                              m_axil_wready_i,
  input  wire [1:0]                        m_axil_bresp_i,
  input  wire                              m_axil_bvalid_i,
  output logic                             m_axil_bready_o,
  output logic [addr_width_p-1:0]          m_axil_araddr_o,
  output logic                             m_axil_arvalid_o,
  input  wire                              m_axil_arready_i,
  input  wire [data_width_p-1:0]           m_axil_rdata_i,
  input  wire [1:0]                        m_axil_rresp_i,
  input  wire                              m_axil_rvalid_i,
  output logic                             m_axil_rready_o
);

  typedef enum logic [2:0]
  {
    e_idle,
    e_wr_addr_data,
    e_wr_resp,
    e_rd_addr,
    e_rd_data
  } state_e;

  state_e                    state_q;
  logic                      aw_sent_q;
  logic                      w_sent_q;
  logic [addr_width_p-1:0]   addr_q;
  logic [data_width_p-1:0]   wdata_q;
  logic [data_width_p/8-1:0] wstrb_q;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      ar_fire;
  logic                      b_fire;
  logic                      r_fire;

  // One access at a time, take the next request only from idle
  assign req_pop_o = (state_q == e_idle) && req_valid_i;

  assign m_axil_awaddr_o  = addr_q;
  assign m_axil_araddr_o  = addr_q;
  assign m_axil_wdata_o   = wdata_q;
  assign m_axil_wstrb_o   = wstrb_q;
  assign m_axil_awvalid_o = (state_q == e_wr_addr_data) && !aw_sent_q;
  assign m_axil_wvalid_o  = (state_q == e_wr_addr_data) && !w_sent_q;
  assign m_axil_arvalid_o = (state_q == e_rd_addr);
  // Hold off B and R while the packer still holds its result
  assign m_axil_bready_o  = (state_q == e_wr_resp) && !resp_full_i;
  assign m_axil_rready_o  = (state_q == e_rd_data) && !resp_full_i;

  assign aw_fire = m_axil_awvalid_o && m_axil_awready_i;
  assign w_fire  = m_axil_wvalid_o && m_axil_wready_i;
  assign ar_fire = m_axil_arvalid_o && m_axil_arready_i;
  assign b_fire  = m_axil_bvalid_i && m_axil_bready_o;
  assign r_fire  = m_axil_rvalid_i && m_axil_rready_o;

  // Response codes bresp and rresp are not reported
  assign done_o  = b_fire || r_fire;
  assign rdata_o = m_axil_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= e_idle;
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        e_idle:
        begin
          if (req_valid_i)
            state_q <= req_i.write ? e_wr_addr_data : e_rd_addr;
        end
        e_wr_addr_data:
        begin
          // AW and W may complete in either order
          if ((aw_sent_q || aw_fire) && (w_sent_q || w_fire))
          begin
            state_q   <= e_wr_resp;
            aw_sent_q <= 1'b0;
            w_sent_q  <= 1'b0;
          end
          else
          begin
            aw_sent_q <= aw_sent_q || aw_fire;
            w_sent_q  <= w_sent_q || w_fire;
          end
        end
        e_wr_resp:
        begin
          if (b_fire)
            state_q <= e_idle;
        end
        e_rd_addr:
        begin
          if (ar_fire)
            state_q <= e_rd_data;
        end
        e_rd_data:
        begin
          if (r_fire)
            state_q <= e_idle;
        end
        default:
          state_q <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_pop_o)
    begin
      addr_q  <= req_i.addr;
      wdata_q <= req_i.data;
      wstrb_q <= req_i.strb;
    end
  end

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axil_awvalid_o && !m_axil_awready_i |=> m_axil_awvalid_o);
  a_w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axil_wvalid_o && !m_axil_wready_i |=> m_axil_wvalid_o);
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axil_arvalid_o && !m_axil_arready_i |=> m_axil_arvalid_o);

endmodule

`default_nettype wire

/* rtl/bridge_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_queue
#(
  parameter type payload_t = logic,
  parameter int  depth_p   = 2
)
(
  input  wire      clk_i,
  input  wire      arst_n_i,
  input  wire      push_i,
  input  payload_t data_i,
  input  wire      pop_i,
  output payload_t data_o,
  output logic     valid_o,
  output logic     full_o
);

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem_q [depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == cnt_width_lp'(depth_p));

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      // Simultaneous push and pop leaves the count alone
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= data_i;
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_o));
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(pop_i && !valid_o));

endmodule

`default_nettype wire

/* rtl/mem_fwd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_fwd_decoder
#(
  parameter int addr_width_p = axil_bridge_pkg::addr_width_gp,
  parameter int data_width_p = axil_bridge_pkg::data_width_gp
)
(
  input  wire                                clk_i,
  input  wire                                arst_n_i,
  input  wire axil_bridge_pkg::mem_header_s  fwd_header_i,
  input  wire [data_width_p-1:0]             fwd_data_i,
  input  wire                                fwd_v_i,
  output logic                               fwd_ready_and_o,
  input  wire                                req_full_i,
  input  wire                                hdr_full_i,
  output logic                               req_push_o,
  output axil_bridge_pkg::axil_req_s         req_o,
  output logic                               hdr_push_o,
  output axil_bridge_pkg::mem_header_s       hdr_o
);

  logic                    accept;
  logic [addr_width_p-1:0] addr;
  logic [1:0]              byte_off;
  logic [3:0]              strb;
  logic                    aligned;

  // Both queues must have room, request and header move as a pair
  assign fwd_ready_and_o = !req_full_i && !hdr_full_i;
  assign accept          = fwd_v_i && fwd_ready_and_o;

  assign addr     = fwd_header_i.addr;
  assign byte_off = addr[1:0];

  // Lane mask from size, shifted to the addressed byte
  always_comb
  begin
    case (fwd_header_i.size)
      axil_bridge_pkg::e_size_1:
      begin
        strb    = 4'b0001 << byte_off;
        aligned = 1'b1;
      end
      axil_bridge_pkg::e_size_2:
      begin
        strb    = 4'b0011 << byte_off;
        aligned = !byte_off[0];
      end
      axil_bridge_pkg::e_size_4:
      begin
        strb    = 4'b1111 << byte_off;
        aligned = (byte_off == 2'b00);
      end
      default:
      begin
        strb    = 4'b0000;
        aligned = 1'b0;
      end
    endcase
  end

  assign req_push_o  = accept;
  assign hdr_push_o  = accept;
  assign req_o.write = (fwd_header_i.msg_type == axil_bridge_pkg::e_mem_wr);
  assign req_o.addr  = addr;
  assign req_o.data  = fwd_data_i;
  assign req_o.strb  = strb;
  assign hdr_o       = fwd_header_i;

  // Upstream must only send legal, naturally aligned beats
  a_legal_size: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |-> (fwd_header_i.size != 2'b11));
  a_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |-> aligned);

endmodule

`default_nettype wire

/* rtl/mem_rev_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_rev_packer
#(
  parameter int addr_width_p = axil_bridge_pkg::addr_width_gp,
  parameter int data_width_p = axil_bridge_pkg::data_width_gp
)
(
  input  wire                                clk_i,
  input  wire                                arst_n_i,
  input  wire                                done_i,
  input  wire [data_width_p-1:0]             rdata_i,
  input  wire axil_bridge_pkg::mem_header_s  hdr_i,
  input  wire                                hdr_valid_i,
  input  wire                                rev_ready_and_i,
  output logic                               hdr_pop_o,
  output logic                               full_o,
  output axil_bridge_pkg::mem_header_s       rev_header_o,
  output logic [data_width_p-1:0]            rev_data_o,
  output logic                               rev_v_o
);

  logic [addr_width_p-1:0]      hdr_addr;
  logic [1:0]                   lane_off;
  logic [data_width_p-1:0]      shifted;
  logic [data_width_p-1:0]      pack_data;
  logic                         full_q;
  axil_bridge_pkg::mem_header_s hdr_q;
  logic [data_width_p-1:0]      data_q;

  assign hdr_addr = hdr_i.addr;
  assign lane_off = hdr_addr[1:0];
  // Addressed bytes moved down to lane 0
  assign shifted  = rdata_i >> {lane_off, 3'b000};

  always_comb
  begin
    if (hdr_i.msg_type == axil_bridge_pkg::e_mem_wr)
      pack_data = '0;
    else
    begin
      case (hdr_i.size)
        axil_bridge_pkg::e_size_1: pack_data = {4{shifted[7:0]}};
        axil_bridge_pkg::e_size_2: pack_data = {2{shifted[15:0]}};
        default:                   pack_data = rdata_i;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      full_q <= 1'b0;
    else if (done_i)
      full_q <= 1'b1;
    else if (rev_ready_and_i)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (done_i)
    begin
      hdr_q  <= hdr_i;
      data_q <= pack_data;
    end
  end

  // Header leaves its queue only once the reverse beat is taken
  assign hdr_pop_o    = full_q && rev_ready_and_i;
  assign full_o       = full_q;
  assign rev_v_o      = full_q;
  assign rev_header_o = hdr_q;
  assign rev_data_o   = data_q;

  a_hdr_present: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_i |-> hdr_valid_i);
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_i |-> !full_q);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_bridge -f list.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

/* tests/axil_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model
#(
  parameter int          addr_width_p = 32,
  parameter logic [31:0] seed_p       = 32'h1
)
(
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire [addr_width_p-1:0] awaddr_i,
  input  wire                    awvalid_i,
  output logic                   awready_o,
  input  wire [31:0]             wdata_i,
  input  wire [3:0]              wstrb_i,
  input  wire                    wvalid_i,
  output logic                   wready_o,
  output logic [1:0]             bresp_o,
  output logic                   bvalid_o,
  input  wire                    bready_i,
  input  wire [addr_width_p-1:0] araddr_i,
  input  wire                    arvalid_i,
  output logic                   arready_o,
  output logic [31:0]            rdata_o,
  output logic [1:0]             rresp_o,
  output logic                   rvalid_o,
  input  wire                    rready_i
);

  // 64-byte window, word addressed
  logic [31:0] mem [16];
  integer      seed;
  int          aw_cnt;
  int          w_cnt;
  int          b_cnt;
  int          ar_cnt;
  int          r_cnt;
  logic        aw_have;
  logic        w_have;
  logic        ar_have;
  logic        b_go;
  logic        r_go;
  logic [5:0]  aw_addr;
  logic [5:0]  ar_addr;
  logic [31:0] w_data;
  logic [3:0]  w_strb;

  // Stall of 0 to 3 cycles
  function automatic int pick_delay();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  function automatic logic [7:0] fill_byte(int a);
    return 8'(a * 29 + 91);
  endfunction

  task automatic clear_state();
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bresp_o   = 2'b00;
    bvalid_o  = 1'b0;
    arready_o = 1'b0;
    rdata_o   = '0;
    rresp_o   = 2'b00;
    rvalid_o  = 1'b0;
    aw_have   = 1'b0;
    w_have    = 1'b0;
    ar_have   = 1'b0;
    b_go      = 1'b0;
    r_go      = 1'b0;
    aw_addr   = '0;
    ar_addr   = '0;
    w_data    = '0;
    w_strb    = '0;
    aw_cnt    = pick_delay();
    w_cnt     = pick_delay();
    b_cnt     = pick_delay();
    ar_cnt    = pick_delay();
    r_cnt     = pick_delay();
  endtask

  // One cycle of the slave, run at the falling edge
  task automatic step();
    // Handshakes that completed at the last rising edge
    if (b_go)
    begin
      bvalid_o = 1'b0;
      aw_have  = 1'b0;
      w_have   = 1'b0;
      b_go     = 1'b0;
    end
    if (r_go)
    begin
      rvalid_o = 1'b0;
      ar_have  = 1'b0;
      r_go     = 1'b0;
    end

    // Responses first, so B and R never lead their address handshakes
    if (aw_have && w_have && !bvalid_o)
    begin
      if (b_cnt == 0)
      begin
        for (int b = 0; b < 4; b++)
          if (w_strb[b])
            mem[aw_addr[5:2]][b*8 +: 8] = w_data[b*8 +: 8];
        bvalid_o = 1'b1;
        b_cnt    = pick_delay();
      end
      else
        b_cnt--;
    end
    if (bvalid_o && bready_i)
      b_go = 1'b1;

    if (ar_have && !rvalid_o)
    begin
      if (r_cnt == 0)
      begin
        rdata_o  = mem[ar_addr[5:2]];
        rvalid_o = 1'b1;
        r_cnt    = pick_delay();
      end
      else
        r_cnt--;
    end
    if (rvalid_o && rready_i)
      r_go = 1'b1;

    // Ready is raised only with valid present, so the transfer is certain
    awready_o = 1'b0;
    if (awvalid_i && !aw_have)
    begin
      if (aw_cnt == 0)
      begin
        awready_o = 1'b1;
        aw_have   = 1'b1;
        aw_addr   = awaddr_i[5:0];
        aw_cnt    = pick_delay();
      end
      else
        aw_cnt--;
    end

    wready_o = 1'b0;
    if (wvalid_i && !w_have)
    begin
      if (w_cnt == 0)
      begin
        wready_o = 1'b1;
        w_have   = 1'b1;
        w_data   = wdata_i;
        w_strb   = wstrb_i;
        w_cnt    = pick_delay();
      end
      else
        w_cnt--;
    end

    arready_o = 1'b0;
    if (arvalid_i && !ar_have)
    begin
      if (ar_cnt == 0)
      begin
        arready_o = 1'b1;
        ar_have   = 1'b1;
        ar_addr   = araddr_i[5:0];
        ar_cnt    = pick_delay();
      end
      else
        ar_cnt--;
    end
  endtask

  initial
  begin
    seed = seed_p;
    for (int a = 0; a < 64; a++)
      mem[a / 4][(a % 4) * 8 +: 8] = fill_byte(a);
    clear_state();
    forever
    begin
      @(negedge clk_i);
      if (!arst_n_i)
        clear_state();
      else
        step();
    end
  end

endmodule

`default_nettype wire

/* tests/tb_axil_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_bridge;

  localparam int          addr_width_lp = axil_bridge_pkg::addr_width_gp;
  localparam int          data_width_lp = axil_bridge_pkg::data_width_gp;
  localparam int          msg_count_lp  = 300;
  // Generous bound per message with AXI stalls and reverse back-pressure
  localparam int          timeout_lp    = msg_count_lp * 40;
  localparam logic [31:0] seed_lp       = 32'he78e_a2b6;
  localparam logic [31:0] base_addr_lp  = 32'h4000_0000;

  logic                         clk;
  logic                         arst_n;
  axil_bridge_pkg::mem_header_s fwd_header;
  logic [31:0]                  fwd_data;
  logic                         fwd_v;
  logic                         fwd_ready;
  axil_bridge_pkg::mem_header_s rev_header;
  logic [31:0]                  rev_data;
  logic                         rev_v;
  logic                         rev_ready;
  logic [31:0]                  awaddr;
  logic                         awvalid;
  logic                         awready;
  logic [31:0]                  wdata;
  logic [3:0]                   wstrb;
  logic                         wvalid;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         bready;
  logic [31:0]                  araddr;
  logic                         arvalid;
  logic                         arready;
  logic [31:0]                  rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;
  logic                         rready;

  integer                       seed;
  logic [7:0]                   model_mem [64];
  axil_bridge_pkg::mem_header_s exp_hdr_q [$];
  logic [31:0]                  exp_data_q [$];
  axil_bridge_pkg::mem_header_s exp_axi_q [$];
  int                           error_count;
  int                           cycle_count;
  int                           gen_count;
  int                           acc_count;
  int                           rev_count;
  int                           stall_left;
  logic                         fwd_taken;
  logic                         stall_done;
  logic                         saw_block;
  logic                         held_v;
  axil_bridge_pkg::mem_header_s held_hdr;
  logic [31:0]                  held_data;
  logic                         axi_busy;
  logic                         all_done;

  axil_bridge_top #(
    .addr_width_p(addr_width_lp),
    .data_width_p(data_width_lp)
  ) dut0 (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .fwd_header_i(fwd_header),
    .fwd_data_i(fwd_data),
    .fwd_v_i(fwd_v),
    .fwd_ready_and_o(fwd_ready),
    .rev_header_o(rev_header),
    .rev_data_o(rev_data),
    .rev_v_o(rev_v),
    .rev_ready_and_i(rev_ready),
    .m_axil_awaddr_o(awaddr),
    .m_axil_awvalid_o(awvalid),
    .m_axil_awready_i(awready),
    .m_axil_wdata_o(wdata),
    .m_axil_wstrb_o(wstrb),
    .m_axil_wvalid_o(wvalid),
    .m_axil_wready_i(wready),
    .m_axil_bresp_i(bresp),
    .m_axil_bvalid_i(bvalid),
    .m_axil_bready_o(bready),
    .m_axil_araddr_o(araddr),
    .m_axil_arvalid_o(arvalid),
    .m_axil_arready_i(arready),
    .m_axil_rdata_i(rdata),
    .m_axil_rresp_i(rresp),
    .m_axil_rvalid_i(rvalid),
    .m_axil_rready_o(rready)
  );

  axil_mem_model #(
    .addr_width_p(addr_width_lp),
    .seed_p(seed_lp)
  ) mem0 (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .awaddr_i(awaddr),
    .awvalid_i(awvalid),
    .awready_o(awready),
    .wdata_i(wdata),
    .wstrb_i(wstrb),
    .wvalid_i(wvalid),
    .wready_o(wready),
    .bresp_o(bresp),
    .bvalid_o(bvalid),
    .bready_i(bready),
    .araddr_i(araddr),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .rdata_o(rdata),
    .rresp_o(rresp),
    .rvalid_o(rvalid),
    .rready_i(rready)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Same start pattern as the slave memory
  function automatic logic [7:0] fill_byte(int a);
    return 8'(a * 29 + 91);
  endfunction

  // Addressed bytes repeated across all four lanes
  function automatic logic [31:0] read_lanes(logic [5:0] off, int nbytes);
    logic [31:0] word;
    word = '0;
    for (int j = 0; j < 4; j++)
      word[j*8 +: 8] = model_mem[off + (j % nbytes)];
    return word;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got == expected)
    else
    begin
      error_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_reset_outputs();
    check_value("rev_v_o", rev_v, 64'd0);
    check_value("m_axil_awvalid_o", awvalid, 64'd0);
    check_value("m_axil_wvalid_o", wvalid, 64'd0);
    check_value("m_axil_arvalid_o", arvalid, 64'd0);
    check_value("m_axil_bready_o", bready, 64'd0);
    check_value("m_axil_rready_o", rready, 64'd0);
    check_value("fwd_ready_and_o", fwd_ready, 64'd1);
  endtask

  // Direction and address of a new AXI access against the oldest message not yet issued
  task automatic check_access();
    axil_bridge_pkg::mem_header_s hdr;
    logic                         is_write;
    assert (exp_axi_q.size() != 0)
    else
    begin
      error_count++;
      $display("An AXI access started at %0t with no forward message waiting", $time);
    end
    if (exp_axi_q.size() != 0)
    begin
      hdr      = exp_axi_q.pop_front();
      is_write = (hdr.msg_type == axil_bridge_pkg::e_mem_wr);
      check_value("m_axil_awvalid_o", awvalid, is_write);
      check_value("m_axil_wvalid_o", wvalid, is_write);
      check_value("m_axil_arvalid_o", arvalid, !is_write);
      if (is_write)
        check_value("m_axil_awaddr_o", awaddr, hdr.addr);
      else
        check_value("m_axil_araddr_o", araddr, hdr.addr);
    end
  endtask

  task automatic new_message();
    int         size_code;
    logic [5:0] off;
    size_code = rand_below(3);
    off       = 6'(rand_below(64));
    off       = off & ~6'((1 << size_code) - 1);
    fwd_header.msg_type = rand_below(2) ? axil_bridge_pkg::e_mem_wr : axil_bridge_pkg::e_mem_rd;
    fwd_header.size     = axil_bridge_pkg::mem_msg_size_e'(size_code);
    fwd_header.addr     = base_addr_lp | 32'(off);
    fwd_data            = $random(seed);
    fwd_v               = 1'b1;
    gen_count++;
  endtask

  // Accesses run in order, so the model is updated at forward acceptance
  task automatic accept_message();
    logic [5:0]  off;
    int          nbytes;
    logic [31:0] exp_data;
    off    = fwd_header.addr[5:0];
    nbytes = 1 << fwd_header.size;
    if (fwd_header.msg_type == axil_bridge_pkg::e_mem_wr)
    begin
      // Each byte sits in the lane that matches its address
      for (int i = 0; i < nbytes; i++)
        model_mem[off + i] = fwd_data[(off[1:0] + i) * 8 +: 8];
      exp_data = '0;
    end
    else
      exp_data = read_lanes(off, nbytes);
    exp_hdr_q.push_back(fwd_header);
    exp_data_q.push_back(exp_data);
    exp_axi_q.push_back(fwd_header);
    acc_count++;
  endtask

  task automatic take_reverse();
    assert (exp_hdr_q.size() != 0)
    else
    begin
      error_count++;
      $display("A reverse message arrived at %0t with no forward message outstanding", $time);
    end
    if (exp_hdr_q.size() != 0)
    begin
      check_value("rev_header_o", rev_header, exp_hdr_q[0]);
      check_value("rev_data_o", rev_data, exp_data_q[0]);
      void'(exp_hdr_q.pop_front());
      void'(exp_data_q.pop_front());
    end
    rev_count++;
  endtask

  task automatic drive_cycle();
    // Valids rise only after a cycle with none of them high
    if ((awvalid || wvalid || arvalid) && !axi_busy)
      check_access();
    axi_busy = awvalid || wvalid || arvalid;

    // A beat not taken last cycle must still be there unchanged
    if (held_v)
    begin
      assert (rev_v)
      else
      begin
        error_count++;
        $display("rev_v_o dropped at %0t before the beat was accepted", $time);
      end
      check_value("rev_header_o", rev_header, held_hdr);
      check_value("rev_data_o", rev_data, held_data);
    end

    if (stall_left > 0)
    begin
      rev_ready = 1'b0;
      if (!fwd_ready)
        saw_block = 1'b1;
      stall_left--;
      if (stall_left == 0)
      begin
        assert (saw_block)
        else
        begin
          error_count++;
          $display("fwd_ready_and_o never fell while rev_ready_and_i was held low");
        end
      end
    end
    else
      rev_ready = (rand_below(4) != 0);

    if (rev_v && rev_ready)
      take_reverse();
    held_v    = rev_v && !rev_ready;
    held_hdr  = rev_header;
    held_data = rev_data;

    if (fwd_taken)
    begin
      fwd_v     = 1'b0;
      fwd_taken = 1'b0;
    end
    if (!fwd_v && gen_count < msg_count_lp && rand_below(4) != 0)
      new_message();
    if (fwd_v && fwd_ready)
    begin
      accept_message();
      fwd_taken = 1'b1;
      // Long reverse stall once partway through the run
      if (acc_count == 100 && !stall_done)
      begin
        stall_left = 60;
        stall_done = 1'b1;
      end
    end
  endtask

  initial
  begin
    seed        = seed_lp;
    arst_n      = 1'b0;
    fwd_header  = '0;
    fwd_data    = '0;
    fwd_v       = 1'b0;
    rev_ready   = 1'b0;
    error_count = 0;
    cycle_count = 0;
    gen_count   = 0;
    acc_count   = 0;
    rev_count   = 0;
    stall_left  = 0;
    fwd_taken   = 1'b0;
    stall_done  = 1'b0;
    saw_block   = 1'b0;
    held_v      = 1'b0;
    held_hdr    = '0;
    held_data   = '0;
    axi_busy    = 1'b0;
    all_done    = 1'b0;
    for (int a = 0; a < 64; a++)
      model_mem[a] = fill_byte(a);

    repeat (16) @(posedge clk);
    @(negedge clk);
    check_reset_outputs();
    arst_n = 1'b1;

    while (!all_done && cycle_count < timeout_lp)
    begin
      @(negedge clk);
      cycle_count++;
      drive_cycle();
      all_done = (acc_count == msg_count_lp) && (exp_hdr_q.size() == 0);
    end

    if (!all_done)
    begin
      error_count++;
      $display("Timeout after %0d cycles, %0d of %0d reverse messages received",
               cycle_count, rev_count, msg_count_lp);
    end
    assert (stall_done)
    else
    begin
      error_count++;
      $display("The long reverse stall never took place");
    end
    check_value("reverse message count", rev_count, acc_count);
    check_value("forward message count", acc_count, msg_count_lp);
    for (int a = 0; a < 64; a++)
      check_value($sformatf("mem0.mem byte %0d", a),
                  mem0.mem[a / 4][(a % 4) * 8 +: 8], model_mem[a]);

    $display("Summary: %0d errors, %0d forward messages, %0d reverse messages, %0d cycles",
             error_count, acc_count, rev_count, cycle_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
